//--- hdl/axi4_master_data.sv
`timescale 1ns/1ps
`include "cpu_bus_defines.svh"

module axi4_master_data (
    input  logic                      axi4_master,
    input  logic                      rst_n,
    input  cpu_bus_pkg::sram_wr_req_t wr_req,
    output logic                      wr_busy,
    input  cpu_bus_pkg::sram_rd_req_t rd_req,
    output cpu_bus_pkg::sram_rd_rsp_t rd_rsp,
    output cpu_bus_pkg::axi_aw_t      aw,
    output cpu_bus_pkg::axi_w_t       w,
    output cpu_bus_pkg::axi_ar_t      ar,
    input  cpu_bus_pkg::axi_b_t       b,
    input  cpu_bus_pkg::axi_r_t       r,
    input  logic                      aw_ready,
    input  logic                      w_ready,
    input  logic                      ar_ready,
    output logic                      b_ready,
    output logic                      r_ready
);
    import cpu_bus_pkg::*;

    typedef enum logic [1:0] {ws_idle, ws_addr, ws_data, ws_resp} wr_state_t;
    typedef enum logic [1:0] {rs_idle, rs_wait, rs_addr, rs_data} rd_state_t;

    wr_state_t wr_state;
    rd_state_t rd_state;

    logic [`CPU_ADDR_W-1:0] wr_addr_q;
    logic [`CPU_DATA_W-1:0] wr_data_q;
    logic [`CPU_STRB_W-1:0] wr_mask_q;
    logic [`CPU_ADDR_W-1:0] rd_addr_q;
    logic [`CPU_DATA_W-1:0] rd_data_q;
    logic                   rd_valid_q;
    logic                   wr_accept;
    logic                   rd_accept;
    logic                   hazard;     // Held read against the write in flight.
    logic                   hazard_in;  // New read against the write in flight.

    assign wr_accept = (wr_state == ws_idle) && wr_req.en;
    assign rd_accept = (rd_state == rs_idle) && rd_req.en;
    assign wr_busy   = (wr_state != ws_idle);
    assign hazard    = wr_busy && (wr_addr_q == rd_addr_q);
    assign hazard_in = wr_busy && (wr_addr_q == rd_req.addr);

    // ====================
    // Write machine.
    // ====================
    always_ff @(posedge axi4_master) begin
        if (!rst_n) begin
            wr_state <= ws_idle;
        end else begin
            case (wr_state)
                ws_idle: begin
                    if (wr_req.en) begin
                        wr_state <= ws_addr;
                    end
                end
                ws_addr: begin
                    if (aw_ready) begin
                        wr_state <= ws_data;
                    end
                end
                ws_data: begin
                    if (w_ready) begin
                        wr_state <= ws_resp;
                    end
                end
                ws_resp: begin
                    if (b.valid && b.id == ID_DATA) begin
                        wr_state <= ws_idle;
                    end
                end
                default: wr_state <= ws_idle;
            endcase
        end
    end

    always_ff @(posedge axi4_master) begin
        if (wr_accept) begin
            wr_addr_q <= wr_req.addr;
            wr_data_q <= wr_req.data;
            wr_mask_q <= wr_req.mask;
        end
    end

    assign aw      = '{valid: (wr_state == ws_addr), id: ID_DATA, addr: wr_addr_q};
    assign w       = '{valid: (wr_state == ws_data), data: wr_data_q, strb: wr_mask_q};
    assign b_ready = (wr_state == ws_resp);

    // ====================
    // Read machine.
    // ====================
    always_ff @(posedge axi4_master) begin
        if (!rst_n) begin
            rd_state   <= rs_idle;
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= 1'b0;
            case (rd_state)
                rs_idle: begin
                    if (rd_req.en) begin
                        rd_state <= hazard_in ? rs_wait : rs_addr;
                    end
                end
                rs_wait: begin
                    if (!hazard) begin  // Write has landed.
                        rd_state <= rs_addr;
                    end
                end
                rs_addr: begin
                    if (ar_ready) begin
                        rd_state <= rs_data;
                    end
                end
                rs_data: begin
                    if (r.valid && r.id == ID_DATA) begin
                        rd_state   <= rs_idle;
                        rd_valid_q <= 1'b1;
                    end
                end
                default: rd_state <= rs_idle;
            endcase
        end
    end

    always_ff @(posedge axi4_master) begin
        if (rd_accept) begin
            rd_addr_q <= rd_req.addr;
        end
        if (r_ready && r.valid) begin
            rd_data_q <= r.data;
        end
    end

    assign ar      = '{valid: (rd_state == rs_addr), id: ID_DATA, addr: rd_addr_q};
    assign r_ready = (rd_state == rs_data);
    assign rd_rsp  = '{valid: rd_valid_q, data: rd_data_q};

endmodule

//--- hdl/axi4_master_inst.sv
`timescale 1ns/1ps
`include "cpu_bus_defines.svh"

module axi4_master_inst (
    input  logic                      axi4_master,
    input  logic                      rst_n,
    input  cpu_bus_pkg::sram_rd_req_t fetch_req,
    output cpu_bus_pkg::sram_rd_rsp_t fetch_rsp,
    output cpu_bus_pkg::axi_ar_t      ar,
    input  logic                      ar_ready,
    input  cpu_bus_pkg::axi_r_t       r,
    output logic                      r_ready
);
    import cpu_bus_pkg::*;

    typedef enum logic [1:0] {fs_idle, fs_addr, fs_data} fetch_state_t;

    fetch_state_t           state;
    logic [`CPU_ADDR_W-1:0] addr_q;
    logic [`CPU_DATA_W-1:0] data_q;
    logic                   valid_q;
    logic                   r_fire;

    assign r_fire = r.valid && r_ready && (r.id == ID_INST);

    always_ff @(posedge axi4_master) begin
        if (!rst_n) begin
            state   <= fs_idle;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            case (state)
                fs_idle: begin
                    if (fetch_req.en) begin
                        state <= fs_addr;
                    end
                end
                fs_addr: begin
                    if (ar_ready) begin
                        state <= fs_data;
                    end
                end
                fs_data: begin
                    if (r_fire) begin
                        state   <= fs_idle;
                        valid_q <= 1'b1;  // One-cycle pulse.
                    end
                end
                default: state <= fs_idle;
            endcase
        end
    end

    always_ff @(posedge axi4_master) begin
        if (state == fs_idle && fetch_req.en) begin
            addr_q <= fetch_req.addr;
        end
        if (r_fire) begin
            data_q <= r.data;
        end
    end

    assign ar        = '{valid: (state == fs_addr), id: ID_INST, addr: addr_q};
    assign r_ready   = (state == fs_data);
    assign fetch_rsp = '{valid: valid_q, data: data_q};

endmodule

//--- hdl/axi4_read_arbiter.sv
`timescale 1ns/1ps
`include "cpu_bus_defines.svh"

module axi4_read_arbiter (
    input  logic                 axi4_master,
    input  logic                 rst_n,
    input  cpu_bus_pkg::axi_ar_t ar_inst,
    input  cpu_bus_pkg::axi_ar_t ar_data,
    output logic                 ar_ready_inst,
    output logic                 ar_ready_data,
    output cpu_bus_pkg::axi_ar_t ar_out,
    input  logic                 ar_ready_out,
    input  cpu_bus_pkg::axi_r_t  r_in,
    output logic                 r_ready_in,
    output cpu_bus_pkg::axi_r_t  r_inst,
    output cpu_bus_pkg::axi_r_t  r_data,
    input  logic                 r_ready_inst,
    input  logic                 r_ready_data
);
    import cpu_bus_pkg::*;

    logic                 locked;     // A read is granted and not yet returned.
    logic                 gnt_data;
    logic                 prio_data;  // Data side wins the next tie.
    logic                 pick_data;
    logic                 any_req;
    logic [`CPU_ID_W-1:0] gnt_id;
    logic                 r_done;

    assign any_req   = ar_inst.valid || ar_data.valid;
    assign pick_data = ar_data.valid && (!ar_inst.valid || prio_data);
    assign gnt_id    = gnt_data ? ID_DATA : ID_INST;
    assign r_done    = r_in.valid && r_ready_in && (r_in.id == gnt_id);

    always_ff @(posedge axi4_master) begin
        if (!rst_n) begin
            locked    <= 1'b0;
            gnt_data  <= 1'b0;
            prio_data <= 1'b0;
        end else if (!locked) begin
            if (any_req) begin
                locked    <= 1'b1;
                gnt_data  <= pick_data;
                prio_data <= !pick_data;  // Loser goes first next time.
            end
        end else if (r_done) begin
            locked <= 1'b0;
        end
    end

    // Granted request goes out with its ID stamped on.
    assign ar_out = '{
        valid: locked && (gnt_data ? ar_data.valid : ar_inst.valid),
        id:    gnt_id,
        addr:  gnt_data ? ar_data.addr : ar_inst.addr
    };

    assign ar_ready_inst = locked && !gnt_data && ar_ready_out;
    assign ar_ready_data = locked && gnt_data && ar_ready_out;

    // Return path steered by RID.
    assign r_inst = '{
        valid: r_in.valid && (r_in.id == ID_INST),
        id:    r_in.id,
        data:  r_in.data
    };
    assign r_data = '{
        valid: r_in.valid && (r_in.id == ID_DATA),
        id:    r_in.id,
        data:  r_in.data
    };

    assign r_ready_in = (r_in.id == ID_DATA) ? r_ready_data : r_ready_inst;

endmodule

//--- hdl/axi4_slave_ram.sv
`timescale 1ns/1ps
`include "cpu_bus_defines.svh"

module axi4_slave_ram (
    input  logic                  axi4_master,
    input  logic                  rst_n,
    input  cpu_bus_pkg::axi_aw_t  aw,
    input  cpu_bus_pkg::axi_w_t   w,
    input  cpu_bus_pkg::axi_ar_t  ar,
    output cpu_bus_pkg::axi_b_t   b,
    output cpu_bus_pkg::axi_r_t   r,
    output cpu_bus_pkg::axi_rdy_t rdy,
    input  logic                  b_ready,
    input  logic                  r_ready
);
    localparam int IDX_W = $clog2(`RAM_WORDS);

    typedef enum logic [1:0] {ws_idle, ws_data, ws_resp} ram_wr_state_t;
    typedef enum logic {rs_idle, rs_data} ram_rd_state_t;

    ram_wr_state_t wr_state;
    ram_rd_state_t rd_state;

    logic [`CPU_DATA_W-1:0] mem [`RAM_WORDS];
    logic [IDX_W-1:0]       wr_idx_q;
    logic [`CPU_ID_W-1:0]   wr_id_q;
    logic [`CPU_ID_W-1:0]   rd_id_q;
    logic [`CPU_DATA_W-1:0] rd_data_q;
    logic                   aw_fire;
    logic                   w_fire;
    logic                   ar_fire;

    initial begin
        for (int i = 0; i < `RAM_WORDS; i++) begin
            mem[i] = '0;  // Contents start cleared.
        end
    end

    assign aw_fire = aw.valid && (wr_state == ws_idle);
    assign w_fire  = w.valid && (wr_state == ws_data);
    assign ar_fire = ar.valid && (rd_state == rs_idle);

    // ====================
    // Write side.
    // ====================
    always_ff @(posedge axi4_master) begin
        if (!rst_n) begin
            wr_state <= ws_idle;
        end else begin
            case (wr_state)
                ws_idle: if (aw_fire) wr_state <= ws_data;
                ws_data: if (w_fire) wr_state <= ws_resp;
                ws_resp: if (b_ready) wr_state <= ws_idle;
                default: wr_state <= ws_idle;
            endcase
        end
    end

    always_ff @(posedge axi4_master) begin
        if (aw_fire) begin
            wr_idx_q <= aw.addr[IDX_W+1:2];  // Word index, wraps at depth.
            wr_id_q  <= aw.id;
        end
        if (w_fire) begin
            for (int i = 0; i < `CPU_STRB_W; i++) begin
                if (w.strb[i]) begin
                    mem[wr_idx_q][8*i +: 8] <= w.data[8*i +: 8];
                end
            end
        end
    end

    assign b = '{valid: (wr_state == ws_resp), id: wr_id_q};

    // ====================
    // Read side.
    // ====================
    always_ff @(posedge axi4_master) begin
        if (!rst_n) begin
            rd_state <= rs_idle;
        end else begin
            case (rd_state)
                rs_idle: if (ar_fire) rd_state <= rs_data;
                rs_data: if (r_ready) rd_state <= rs_idle;
                default: rd_state <= rs_idle;
            endcase
        end
    end

    always_ff @(posedge axi4_master) begin
        if (ar_fire) begin
            rd_id_q   <= ar.id;
            rd_data_q <= mem[ar.addr[IDX_W+1:2]];
        end
    end

    assign r = '{valid: (rd_state == rs_data), id: rd_id_q, data: rd_data_q};

    assign rdy.aw_ready = (wr_state == ws_idle);
    assign rdy.w_ready  = (wr_state == ws_data);
    assign rdy.ar_ready = (rd_state == rs_idle);
    // Master readies as seen at the RAM.
    assign rdy.b_ready  = b_ready;
    assign rdy.r_ready  = r_ready;

endmodule

//--- hdl/cpu_bus_defines.svh
`ifndef CPU_BUS_DEFINES_SVH
`define CPU_BUS_DEFINES_SVH

// Bus widths.
`define CPU_ADDR_W 32
`define CPU_DATA_W 32
`define CPU_STRB_W 4

// One ID bit tells fetch from data.
`define CPU_ID_W 1

// Slave RAM depth in words.
`define RAM_WORDS 256

`endif

//--- hdl/cpu_bus_pkg.sv
`include "cpu_bus_defines.svh"

package cpu_bus_pkg;

    localparam logic [`CPU_ID_W-1:0] ID_INST = `CPU_ID_W'(0);
    localparam logic [`CPU_ID_W-1:0] ID_DATA = `CPU_ID_W'(1);

    // SRAM-side host ports.
    typedef struct packed {
        logic                   en;
        logic [`CPU_ADDR_W-1:0] addr;
    } sram_rd_req_t;

    typedef struct packed {
        logic                   valid;
        logic [`CPU_DATA_W-1:0] data;
    } sram_rd_rsp_t;

    typedef struct packed {
        logic                   en;
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] data;
        logic [`CPU_STRB_W-1:0] mask;
    } sram_wr_req_t;

    // AXI4 channels, single beat only.
    typedef struct packed {
        logic                   valid;
        logic [`CPU_ID_W-1:0]   id;
        logic [`CPU_ADDR_W-1:0] addr;
    } axi_aw_t;

    typedef struct packed {
        logic                   valid;
        logic [`CPU_ID_W-1:0]   id;
        logic [`CPU_ADDR_W-1:0] addr;
    } axi_ar_t;

    typedef struct packed {
        logic                   valid;
        logic [`CPU_DATA_W-1:0] data;
        logic [`CPU_STRB_W-1:0] strb;
    } axi_w_t;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_ID_W-1:0] id;
    } axi_b_t;

    typedef struct packed {
        logic                   valid;
        logic [`CPU_ID_W-1:0]   id;
        logic [`CPU_DATA_W-1:0] data;
    } axi_r_t;

    typedef struct packed {
        logic aw_ready;  // Slave to master.
        logic w_ready;   // Slave to master.
        logic ar_ready;  // Slave to master.
        logic b_ready;   // Master to slave.
        logic r_ready;   // Master to slave.
    } axi_rdy_t;

endpackage

//--- hdl/cpu_bus_top.sv
`timescale 1ns/1ps

module cpu_bus_top (
    input  logic                      axi4_master,
    input  logic                      rst_n,
    input  cpu_bus_pkg::sram_rd_req_t inst_req,
    input  cpu_bus_pkg::sram_rd_req_t data_rd_req,
    output cpu_bus_pkg::sram_rd_rsp_t inst_rsp,
    output cpu_bus_pkg::sram_rd_rsp_t data_rd_rsp,
    input  cpu_bus_pkg::sram_wr_req_t data_wr_req,
    output logic                      data_wr_busy
);
    import cpu_bus_pkg::*;

    axi_aw_t  aw;
    axi_w_t   w;
    axi_ar_t  ar_inst;
    axi_ar_t  ar_data;
    axi_ar_t  ar_mem;
    axi_b_t   b;
    axi_r_t   r_mem;
    axi_r_t   r_inst;
    axi_r_t   r_data;
    axi_rdy_t rdy;
    logic     b_ready;
    logic     r_ready_mem;
    logic     r_ready_inst;
    logic     r_ready_data;
    logic     ar_ready_inst;
    logic     ar_ready_data;

    axi4_master_data u_data (
        .axi4_master(axi4_master), .rst_n(rst_n),
        .wr_req(data_wr_req), .wr_busy(data_wr_busy),
        .rd_req(data_rd_req), .rd_rsp(data_rd_rsp),
        .aw(aw), .w(w), .ar(ar_data), .b(b), .r(r_data),
        .aw_ready(rdy.aw_ready), .w_ready(rdy.w_ready), .ar_ready(ar_ready_data),
        .b_ready(b_ready), .r_ready(r_ready_data)
    );

    axi4_master_inst u_inst (
        .axi4_master(axi4_master), .rst_n(rst_n),
        .fetch_req(inst_req), .fetch_rsp(inst_rsp),
        .ar(ar_inst), .ar_ready(ar_ready_inst),
        .r(r_inst), .r_ready(r_ready_inst)
    );

    axi4_read_arbiter u_arb (
        .axi4_master(axi4_master), .rst_n(rst_n),
        .ar_inst(ar_inst), .ar_data(ar_data),
        .ar_ready_inst(ar_ready_inst), .ar_ready_data(ar_ready_data),
        .ar_out(ar_mem), .ar_ready_out(rdy.ar_ready),
        .r_in(r_mem), .r_ready_in(r_ready_mem),
        .r_inst(r_inst), .r_data(r_data),
        .r_ready_inst(r_ready_inst), .r_ready_data(r_ready_data)
    );

    axi4_slave_ram u_ram (
        .axi4_master(axi4_master), .rst_n(rst_n),
        .aw(aw), .w(w), .ar(ar_mem),
        .b(b), .r(r_mem), .rdy(rdy),
        .b_ready(b_ready), .r_ready(r_ready_mem)
    );

endmodule

//--- list.f
+incdir+hdl
hdl/cpu_bus_pkg.sv
hdl/axi4_master_data.sv
hdl/axi4_master_inst.sv
hdl/axi4_read_arbiter.sv
hdl/axi4_slave_ram.sv
hdl/cpu_bus_top.sv
test/cpu_bus_asserts.sv
test/cpu_bus_tb.sv

//--- test/cpu_bus_asserts.sv
`timescale 1ns/1ps

module cpu_bus_asserts (
    input logic                      axi4_master,
    input logic                      rst_n,
    input cpu_bus_pkg::axi_aw_t      aw,
    input cpu_bus_pkg::axi_w_t       w,
    input cpu_bus_pkg::axi_ar_t      ar,
    input logic                      aw_ready,
    input logic                      w_ready,
    input logic                      ar_ready,
    input cpu_bus_pkg::sram_rd_rsp_t rd_rsp,
    input logic                      hazard
);
    int fail_count = 0;  // Failed assertions so far.

    // ====================
    // Channel stability.
    // ====================
    aw_hold: assert property (@(posedge axi4_master) disable iff (!rst_n)
        aw.valid && !aw_ready |=> aw.valid && $stable(aw))
        else begin
            $error("AW dropped or changed before AWREADY");
            fail_count++;
        end

    w_hold: assert property (@(posedge axi4_master) disable iff (!rst_n)
        w.valid && !w_ready |=> w.valid && $stable(w))
        else begin
            $error("W dropped or changed before WREADY");
            fail_count++;
        end

    ar_hold: assert property (@(posedge axi4_master) disable iff (!rst_n)
        ar.valid && !ar_ready |=> ar.valid && $stable(ar))
        else begin
            $error("AR dropped or changed before ARREADY");
            fail_count++;
        end

    // ====================
    // Read side.
    // ====================
    rd_pulse: assert property (@(posedge axi4_master) disable iff (!rst_n)
        rd_rsp.valid |=> !rd_rsp.valid)
        else begin
            $error("Read valid held for two cycles");
            fail_count++;
        end

    no_stale_read: assert property (@(posedge axi4_master) disable iff (!rst_n)
        !(ar.valid && hazard))
        else begin
            $error("ARVALID raised against a same-address write in flight");
            fail_count++;
        end

endmodule

bind axi4_master_data cpu_bus_asserts u_asserts (
    .axi4_master(axi4_master), .rst_n(rst_n),
    .aw(aw), .w(w), .ar(ar),
    .aw_ready(aw_ready), .w_ready(w_ready), .ar_ready(ar_ready),
    .rd_rsp(rd_rsp), .hazard(hazard)
);

//--- test/cpu_bus_tb.sv
`timescale 1ns/1ps
`include "cpu_bus_defines.svh"

module cpu_bus_tb;
    import cpu_bus_pkg::*;

    localparam int WAIT_LIMIT = 200;  // Cycles.

    logic         axi4_master;
    logic         rst_n;
    sram_rd_req_t inst_req;
    sram_rd_req_t data_rd_req;
    sram_rd_rsp_t inst_rsp;
    sram_rd_rsp_t data_rd_rsp;
    sram_wr_req_t data_wr_req;
    logic         data_wr_busy;

    logic [`CPU_DATA_W-1:0] ref_mem [`RAM_WORDS];
    logic [`CPU_ADDR_W-1:0] data_exp_q [$];  // Addresses of reads in flight.
    logic [`CPU_ADDR_W-1:0] inst_exp_q [$];
    logic [31:0]            lfsr;
    int                     err_count;

    cpu_bus_top UUT (
        .axi4_master(axi4_master), .rst_n(rst_n),
        .inst_req(inst_req), .data_rd_req(data_rd_req),
        .inst_rsp(inst_rsp), .data_rd_rsp(data_rd_rsp),
        .data_wr_req(data_wr_req), .data_wr_busy(data_wr_busy)
    );

    initial begin
        axi4_master = 1'b0;
        forever #2 axi4_master = ~axi4_master;
    end

    // ====================
    // Random source and reference model.
    // ====================
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    // 16 words, aliased above the RAM depth.
    function automatic logic [31:0] random_addr();
        logic [31:0] hi;
        hi = rand_bits(2) << 10;
        return hi | (rand_bits(4) << 2);
    endfunction

    function automatic int ref_index(input logic [31:0] addr);
        return (addr >> 2) % `RAM_WORDS;
    endfunction

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        return ref_mem[ref_index(addr)];
    endfunction

    function automatic void ref_write(input logic [31:0] addr, input logic [31:0] data,
                                      input logic [3:0] mask);
        for (int i = 0; i < `CPU_STRB_W; i++) begin
            if (mask[i]) begin
                ref_mem[ref_index(addr)][8*i +: 8] = data[8*i +: 8];
            end
        end
    endfunction

    // ====================
    // Checking.
    // ====================
    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            err_count++;
            $display("CHECK FAILED at %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Checks failed");
            $fatal(1, "stopped on mismatch");
        end
    endtask

    task automatic stop_run(input string why);
        $display("ERROR at %0t: %s", $time, why);
        $display("Checks failed");
        $fatal(1, "stopped on error");
    endtask

    // Read responses are registered, so the edge sees the pulse of the cycle before.
    always @(posedge axi4_master) begin
        if (rst_n && data_rd_rsp.valid) begin
            if (data_exp_q.size() == 0) begin
                stop_run("data read response arrived with no read outstanding");
            end else begin
                check_value(data_rd_rsp.data, ref_word(data_exp_q.pop_front()), "data read");
            end
        end
        if (rst_n && inst_rsp.valid) begin
            if (inst_exp_q.size() == 0) begin
                stop_run("fetch response arrived with no fetch outstanding");
            end else begin
                check_value(inst_rsp.data, ref_word(inst_exp_q.pop_front()), "fetch");
            end
        end
    end

    // Protocol assertions bound into the data bridge.
    always @(negedge axi4_master) begin
        if (UUT.u_data.u_asserts.fail_count != 0) begin
            stop_run("a protocol assertion in the data bridge failed");
        end
    end

    // ====================
    // Stimulus, all on the falling edge.
    // ====================
    task automatic set_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] mask);
        data_wr_req = '{en: 1'b1, addr: addr, data: data, mask: mask};
        ref_write(addr, data, mask);
    endtask

    task automatic set_data_read(input logic [31:0] addr);
        data_rd_req = '{en: 1'b1, addr: addr};
        data_exp_q.push_back(addr);
    endtask

    task automatic set_fetch(input logic [31:0] addr);
        inst_req = '{en: 1'b1, addr: addr};
        inst_exp_q.push_back(addr);
    endtask

    task automatic end_pulse();
        @(negedge axi4_master);
        data_wr_req.en = 1'b0;
        data_rd_req.en = 1'b0;
        inst_req.en    = 1'b0;
    endtask

    task automatic wait_write_done();
        int n;
        n = 0;
        while (data_wr_busy) begin
            @(negedge axi4_master);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_run("write did not complete in time");
            end
        end
    endtask

    task automatic wait_reads_done();
        int n;
        n = 0;
        while (data_exp_q.size() != 0 || inst_exp_q.size() != 0) begin
            @(negedge axi4_master);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_run("read response did not arrive in time");
            end
        end
    endtask

    task automatic write_and_wait(input logic [31:0] addr, input logic [3:0] mask);
        logic [31:0] d;
        d = rand_bits(32);
        set_write(addr, d, mask);
        end_pulse();
        wait_write_done();
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic [1:0]  op;
        lfsr        = 32'h01c9_841a;
        err_count   = 0;
        rst_n       = 1'b0;
        inst_req    = '0;
        data_rd_req = '0;
        data_wr_req = '0;
        for (int i = 0; i < `RAM_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (5) @(posedge axi4_master);
        @(negedge axi4_master);
        rst_n = 1'b1;

        repeat (2) @(negedge axi4_master);
        check_value(data_wr_busy, 0, "write busy after reset");
        check_value(inst_rsp.valid, 0, "fetch valid after reset");
        check_value(data_rd_rsp.valid, 0, "data read valid after reset");

        // Masked write merges into old bytes.
        a = random_addr();
        write_and_wait(a, 4'hf);
        write_and_wait(a, rand_bits(4));
        set_data_read(a);
        end_pulse();
        wait_reads_done();

        set_fetch(a);
        end_pulse();
        wait_reads_done();

        // Read right behind a write to the same word must stall.
        a = random_addr();
        d = rand_bits(32);
        set_write(a, d, 4'hf);
        end_pulse();
        set_data_read(a);
        end_pulse();
        wait_reads_done();
        wait_write_done();

        repeat (20) begin
            set_fetch(random_addr());
            set_data_read(random_addr());
            end_pulse();
            wait_reads_done();
        end

        repeat (200) begin
            op = rand_bits(2);
            case (op)
                2'd0: write_and_wait(random_addr(), rand_bits(4));
                2'd1: set_data_read(random_addr());
                2'd2: set_fetch(random_addr());
                default: begin
                    set_fetch(random_addr());
                    set_data_read(random_addr());
                end
            endcase
            if (op != 2'd0) begin
                end_pulse();
                wait_reads_done();
            end
        end

        if (err_count == 0 && UUT.u_data.u_asserts.fail_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1, "run ended with errors");
        end
    end

endmodule
